// ==== testbench/issue_tb.sv ====
/*
 * Issue stage testbench
 * Random decode traffic into the issue stage, with the ALU and LSU played
 * here and every dispatched request checked against a reference model
 */
`default_nettype none

module issue_tb;

    localparam int NUM_WARPS  = 4;
    localparam int IBUF_DEPTH = 4;
    localparam int PERF_BITS  = 16;
    localparam int NUM_INSTS  = 300;
    localparam int TIMEOUT    = 20000;

    logic                        clk;
    logic                        reset;
    logic                        decode_valid;
    issue_pkg::decode_t          decode;
    logic                        decode_ready;
    logic                        wb_valid;
    issue_pkg::writeback_t       wb;
    logic                        alu_valid;
    issue_pkg::alu_req_t         alu_req;
    logic                        alu_ready;
    logic                        lsu_valid;
    issue_pkg::lsu_req_t         lsu_req;
    logic                        lsu_ready;
    logic [PERF_BITS-1:0]        ibuf_stalls;
    logic [PERF_BITS-1:0]        scb_stalls;

    // Reference model state
    logic [31:0] model_regs [NUM_WARPS][gpu_isa_pkg::NUM_REGS];
    logic        model_pending [NUM_WARPS][gpu_isa_pkg::NUM_REGS];
    issue_pkg::decode_t    expect_q [$];
    issue_pkg::writeback_t pend_wb [$];
    int                    pend_due [$];
    logic [31:0]           next_pc [NUM_WARPS];

    logic [31:0]          lfsr_state;
    logic                 running;
    int                   cycle;
    int                   generated;
    int                   accepted;
    int                   seen_ibuf_stalls;
    logic [PERF_BITS-1:0] last_scb;
    logic                 alu_hold;
    logic                 lsu_hold;
    issue_pkg::alu_req_t  alu_held;
    issue_pkg::lsu_req_t  lsu_held;

    issue_top #(
        .NUM_WARPS  (NUM_WARPS),
        .IBUF_DEPTH (IBUF_DEPTH),
        .PERF_BITS  (PERF_BITS)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .decode_valid (decode_valid),
        .decode       (decode),
        .decode_ready (decode_ready),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .alu_valid    (alu_valid),
        .alu_req      (alu_req),
        .alu_ready    (alu_ready),
        .lsu_valid    (lsu_valid),
        .lsu_req      (lsu_req),
        .lsu_ready    (lsu_ready),
        .ibuf_stalls  (ibuf_stalls),
        .scb_stalls   (scb_stalls)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR, taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] sign_extend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] reg_value(input int w, input int r);
        return (r == 0) ? 32'd0 : model_regs[w][r];
    endfunction

    function automatic logic is_memory_op(input gpu_isa_pkg::opcode_e op);
        return (op == gpu_isa_pkg::OP_LOAD) || (op == gpu_isa_pkg::OP_STORE);
    endfunction

    function automatic logic expect_wb(input issue_pkg::decode_t d);
        return (d.op != gpu_isa_pkg::OP_STORE) && (d.rd != '0);
    endfunction

    // Index of the oldest accepted decode of a warp, or -1
    function automatic int find_oldest(input logic [1:0] wid);
        int idx;
        idx = -1;
        for (int i = 0; i < expect_q.size(); i++) begin
            if (idx < 0 && expect_q[i].wid == wid) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at time %0t: %s, got 0x%0h, expected 0x%0h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_hazard(input issue_pkg::decode_t d);
        check_equal(model_pending[d.wid][d.rs1], 1'b0, "rs1 still pending at dispatch");
        check_equal(model_pending[d.wid][d.rs2], 1'b0, "rs2 still pending at dispatch");
        check_equal(model_pending[d.wid][d.rd], 1'b0, "rd still pending at dispatch");
    endtask

    // Results return after a random delay, so the register is busy until then
    task automatic schedule_writeback(input issue_pkg::decode_t d);
        issue_pkg::writeback_t ret;
        ret.wid  = d.wid;
        ret.rd   = d.rd;
        ret.data = '0;
        model_pending[d.wid][d.rd] = 1'b1;
        pend_wb.push_back(ret);
        pend_due.push_back(cycle + 1 + int'(rand_bits(3)));
    endtask

    task automatic accept_alu();
        issue_pkg::decode_t d;
        int idx;
        idx = find_oldest(alu_req.wid);
        if (idx < 0) begin
            abort_run("ALU request arrived for a warp with no decode outstanding");
        end else begin
            d = expect_q[idx];
            check_equal(alu_req.pc, d.pc, "ALU pc");
            check_equal(alu_req.op, d.op, "ALU op");
            check_equal(alu_req.rd, d.rd, "ALU rd");
            check_equal(is_memory_op(d.op), 1'b0, "memory op on ALU port");
            check_equal(alu_req.wb, expect_wb(d), "ALU wb flag");
            check_hazard(d);
            check_equal(alu_req.a, reg_value(d.wid, d.rs1), "ALU operand a");
            check_equal(alu_req.b, d.use_imm ? sign_extend(d.imm) : reg_value(d.wid, d.rs2),
                        "ALU operand b");
            expect_q.delete(idx);
            if (expect_wb(d)) begin
                schedule_writeback(d);
            end
        end
    endtask

    task automatic accept_lsu();
        issue_pkg::decode_t d;
        int idx;
        idx = find_oldest(lsu_req.wid);
        if (idx < 0) begin
            abort_run("LSU request arrived for a warp with no decode outstanding");
        end else begin
            d = expect_q[idx];
            check_equal(lsu_req.pc, d.pc, "LSU pc");
            check_equal(is_memory_op(d.op), 1'b1, "non-memory op on LSU port");
            check_equal(lsu_req.is_store, d.op == gpu_isa_pkg::OP_STORE, "LSU store flag");
            check_equal(lsu_req.rd, d.rd, "LSU rd");
            check_equal(lsu_req.wb, expect_wb(d), "LSU wb flag");
            check_hazard(d);
            check_equal(lsu_req.addr, 32'(reg_value(d.wid, d.rs1) + sign_extend(d.imm)),
                        "LSU address");
            check_equal(lsu_req.wdata, reg_value(d.wid, d.rs2), "LSU store data");
            expect_q.delete(idx);
            if (expect_wb(d)) begin
                schedule_writeback(d);
            end
        end
    endtask

    task automatic drive_decode();
        issue_pkg::decode_t d;
        // A pending decode is held until the buffer takes it
        if (!decode_valid || decode_ready) begin
            if (generated < NUM_INSTS && rand_bits(2) != 32'd0) begin
                d.wid     = 2'(rand_bits(2));
                d.pc      = next_pc[d.wid];
                d.op      = gpu_isa_pkg::opcode_e'(4'(rand_bits(3)));
                d.rd      = 5'(rand_bits(3));
                d.rs1     = 5'(rand_bits(3));
                d.rs2     = 5'(rand_bits(3));
                d.use_imm = 1'(rand_bits(1));
                d.imm     = 16'(rand_bits(16));
                next_pc[d.wid] = next_pc[d.wid] + 32'd4;
                generated++;
                decode       <= d;
                decode_valid <= 1'b1;
            end else begin
                decode_valid <= 1'b0;
            end
        end
    endtask

    task automatic return_writeback();
        issue_pkg::writeback_t ret;
        int pick;
        pick = -1;
        for (int i = 0; i < pend_wb.size(); i++) begin
            if (pick < 0 && pend_due[i] <= cycle) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            ret      = pend_wb[pick];
            ret.data = rand_bits(32);
            model_regs[ret.wid][ret.rd]    = ret.data;
            model_pending[ret.wid][ret.rd] = 1'b0;
            pend_wb.delete(pick);
            pend_due.delete(pick);
            wb       <= ret;
            wb_valid <= 1'b1;
        end else begin
            wb_valid <= 1'b0;
        end
    endtask

    // Samples the DUT before the edge takes effect, then drives the next cycle
    always @(posedge clk) begin
        if (running) begin
            cycle++;
            check_equal(ibuf_stalls, PERF_BITS'(seen_ibuf_stalls), "ibuf_stalls count");
            check_equal(scb_stalls >= last_scb, 1'b1, "scb_stalls went down");
            last_scb = scb_stalls;
            if (decode_valid && !decode_ready) begin
                seen_ibuf_stalls++;
            end
            if (alu_valid && lsu_valid) begin
                abort_run("ALU and LSU requests were valid in the same cycle");
            end
            if (alu_hold) begin
                check_equal(alu_valid, 1'b1, "ALU valid dropped under back-pressure");
                check_equal(alu_req, alu_held, "ALU request changed under back-pressure");
            end
            if (lsu_hold) begin
                check_equal(lsu_valid, 1'b1, "LSU valid dropped under back-pressure");
                check_equal(lsu_req, lsu_held, "LSU request changed under back-pressure");
            end
            alu_hold = alu_valid && !alu_ready;
            lsu_hold = lsu_valid && !lsu_ready;
            alu_held = alu_req;
            lsu_held = lsu_req;
            if (alu_valid && alu_ready) begin
                accept_alu();
            end
            if (lsu_valid && lsu_ready) begin
                accept_lsu();
            end
            if (decode_valid && decode_ready) begin
                expect_q.push_back(decode);
                accepted++;
            end
            drive_decode();
            return_writeback();
            alu_ready <= (rand_bits(2) != 32'd0);
            lsu_ready <= (rand_bits(2) != 32'd0);
        end
    end

    initial begin
        int timer;
        issue_pkg::writeback_t init_wb;
        lfsr_state       = 32'hccc427f2;
        running          = 1'b0;
        cycle            = 0;
        generated        = 0;
        accepted         = 0;
        seen_ibuf_stalls = 0;
        last_scb         = '0;
        alu_hold         = 1'b0;
        lsu_hold         = 1'b0;
        reset            = 1'b1;
        decode_valid     = 1'b0;
        decode           = '0;
        wb_valid         = 1'b0;
        wb               = '0;
        alu_ready        = 1'b0;
        lsu_ready        = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            next_pc[w] = 32'h100 * w;
            for (int r = 0; r < gpu_isa_pkg::NUM_REGS; r++) begin
                model_pending[w][r] = 1'b0;
            end
        end

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_equal(alu_valid, 1'b0, "alu_valid after reset");
        check_equal(lsu_valid, 1'b0, "lsu_valid after reset");
        check_equal(decode_ready, 1'b1, "decode_ready after reset");
        check_equal(ibuf_stalls, '0, "ibuf_stalls after reset");
        check_equal(scb_stalls, '0, "scb_stalls after reset");

        // Give the register pool of every warp a known value
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int r = 1; r < 8; r++) begin
                @(posedge clk);
                model_regs[w][r] = rand_bits(32);
                init_wb.wid  = 2'(w);
                init_wb.rd   = 5'(r);
                init_wb.data = model_regs[w][r];
                wb_valid <= 1'b1;
                wb       <= init_wb;
            end
        end
        @(posedge clk);
        wb_valid <= 1'b0;
        running  <= 1'b1;

        timer = 0;
        while (accepted < NUM_INSTS) begin
            @(negedge clk);
            timer++;
            if (timer > TIMEOUT) begin
                abort_run("Timed out waiting for the issue stage to accept all decodes");
            end
        end

        timer = 0;
        while (expect_q.size() != 0 || pend_wb.size() != 0 || decode_valid ||
               alu_valid || lsu_valid) begin
            @(negedge clk);
            timer++;
            if (timer > TIMEOUT) begin
                abort_run("Timed out waiting for outstanding instructions to drain");
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/gpu_isa_pkg.sv ====
/*
 * GPU ISA definitions
 * Data and register widths, warp index width, opcodes and the
 * execute-unit selector shared by the issue stage
 */
`default_nettype none

package gpu_isa_pkg;

    // Datapath and register file geometry
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_BITS = 5;

    // Immediate field as carried by a decoded instruction
    localparam int IMM_BITS = 16;

    // Warp index width, wide enough for up to 4 warps
    localparam int WID_BITS = 2;

    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLT   = 4'd5,
        OP_LOAD  = 4'd6,
        OP_STORE = 4'd7
    } opcode_e;

    typedef enum logic {
        EX_ALU = 1'b0,
        EX_LSU = 1'b1
    } ex_unit_e;

endpackage

`default_nettype wire

// ==== verilog/issue_dispatch.sv ====
/*
 * Dispatch stage
 * Routes each instruction to the ALU or LSU port and forms its
 * operands, holding one request at a time to keep program order
 */
`default_nettype none

module issue_dispatch (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  opnd_valid,
    input  issue_pkg::operands_t opnd,
    output logic                 opnd_ready,

    output logic                 alu_valid,
    output issue_pkg::alu_req_t  alu_req,
    input  wire                  alu_ready,

    output logic                 lsu_valid,
    output issue_pkg::lsu_req_t  lsu_req,
    input  wire                  lsu_ready
);

    localparam int XLEN = gpu_isa_pkg::XLEN;
    localparam int IMM_BITS = gpu_isa_pkg::IMM_BITS;

    issue_pkg::decode_t    inst;
    gpu_isa_pkg::ex_unit_e ex_unit;
    logic [XLEN-1:0]       imm_ext;
    logic                  opnd_fire;
    issue_pkg::alu_req_t   alu_next;
    issue_pkg::lsu_req_t   lsu_next;

    assign inst    = opnd.req.inst;
    assign imm_ext = {{(XLEN - IMM_BITS){inst.imm[IMM_BITS-1]}}, inst.imm};

    assign ex_unit = (inst.op == gpu_isa_pkg::OP_LOAD || inst.op == gpu_isa_pkg::OP_STORE) ?
                     gpu_isa_pkg::EX_LSU : gpu_isa_pkg::EX_ALU;

    // Only one port is ever loaded, so a single drain test suffices
    assign opnd_ready = (!alu_valid && !lsu_valid) ||
                        (alu_valid && alu_ready) ||
                        (lsu_valid && lsu_ready);
    assign opnd_fire  = opnd_valid && opnd_ready;

    always_comb begin
        alu_next.wid = inst.wid;
        alu_next.pc  = inst.pc;
        alu_next.op  = inst.op;
        alu_next.wb  = opnd.req.wb;
        alu_next.rd  = inst.rd;
        alu_next.a   = opnd.rs1_data;
        alu_next.b   = inst.use_imm ? imm_ext : opnd.rs2_data;

        lsu_next.wid      = inst.wid;
        lsu_next.pc       = inst.pc;
        lsu_next.is_store = (inst.op == gpu_isa_pkg::OP_STORE);
        lsu_next.wb       = opnd.req.wb;
        lsu_next.rd       = inst.rd;
        lsu_next.addr     = opnd.rs1_data + imm_ext;
        lsu_next.wdata    = opnd.rs2_data;
    end

    always_ff @(posedge clk) begin
        if (opnd_fire && ex_unit == gpu_isa_pkg::EX_ALU) begin
            alu_req <= alu_next;
        end
        if (opnd_fire && ex_unit == gpu_isa_pkg::EX_LSU) begin
            lsu_req <= lsu_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_valid <= 1'b0;
            lsu_valid <= 1'b0;
        end else if (opnd_ready) begin
            alu_valid <= opnd_valid && (ex_unit == gpu_isa_pkg::EX_ALU);
            lsu_valid <= opnd_valid && (ex_unit == gpu_isa_pkg::EX_LSU);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_ibuffer.sv ====
/*
 * Instruction buffer
 * One circular FIFO per warp holding decoded instructions, with the
 * oldest entry of every warp presented to the scheduler
 */
`default_nettype none

module issue_ibuffer #(
    parameter int NUM_WARPS  = 4,
    parameter int IBUF_DEPTH = 4
) (
    input  wire                                    clk,
    input  wire                                    reset,

    input  wire                                    decode_valid,
    input  issue_pkg::decode_t                     decode,
    output logic                                   decode_ready,

    output logic [NUM_WARPS-1:0]                   head_valid,
    output issue_pkg::decode_t [NUM_WARPS-1:0]     head,
    input  wire  [NUM_WARPS-1:0]                   pop
);

    // Depth is a power of two of at least 2, so pointers wrap on their own
    localparam int PTR_BITS = $clog2(IBUF_DEPTH);
    localparam int CNT_BITS = $clog2(IBUF_DEPTH + 1);

    issue_pkg::decode_t   mem [NUM_WARPS][IBUF_DEPTH];
    logic [PTR_BITS-1:0]  wr_ptr [NUM_WARPS];
    logic [PTR_BITS-1:0]  rd_ptr [NUM_WARPS];
    logic [CNT_BITS-1:0]  count [NUM_WARPS];

    logic [NUM_WARPS-1:0] full;
    logic [NUM_WARPS-1:0] push;
    logic [NUM_WARPS-1:0] do_pop;

    always_comb begin
        decode_ready = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            full[w]       = (count[w] == CNT_BITS'(IBUF_DEPTH));
            head_valid[w] = (count[w] != '0);
            head[w]       = mem[w][rd_ptr[w]];
            // A warp index beyond NUM_WARPS is never accepted
            if (decode.wid == gpu_isa_pkg::WID_BITS'(w)) begin
                decode_ready = ~full[w];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            push[w]   = decode_valid && decode_ready &&
                        (decode.wid == gpu_isa_pkg::WID_BITS'(w));
            do_pop[w] = pop[w] && head_valid[w];
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (push[w]) begin
                mem[w][wr_ptr[w]] <= decode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                wr_ptr[w] <= '0;
                rd_ptr[w] <= '0;
                count[w]  <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                if (push[w]) begin
                    wr_ptr[w] <= wr_ptr[w] + 1'b1;
                end
                if (do_pop[w]) begin
                    rd_ptr[w] <= rd_ptr[w] + 1'b1;
                end
                // Simultaneous push and pop leave the count unchanged
                case ({push[w], do_pop[w]})
                    2'b10:   count[w] <= count[w] + 1'b1;
                    2'b01:   count[w] <= count[w] - 1'b1;
                    default: count[w] <= count[w];
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_operands.sv ====
/*
 * Operand read stage
 * Per-warp register file written by writebacks, read into a single
 * pipeline register when the scheduler issues
 */
`default_nettype none

module issue_operands #(
    parameter int NUM_WARPS = 4
) (
    input  wire                   clk,
    input  wire                   reset,

    input  wire                   read_valid,
    input  issue_pkg::read_req_t  read_req,
    output logic                  read_ready,

    input  wire                   wb_valid,
    input  issue_pkg::writeback_t wb,

    output logic                  opnd_valid,
    output issue_pkg::operands_t  opnd,
    input  wire                   opnd_ready
);

    localparam int WB = gpu_isa_pkg::WID_BITS;

    logic [gpu_isa_pkg::XLEN-1:0] regs [NUM_WARPS][gpu_isa_pkg::NUM_REGS];

    logic [gpu_isa_pkg::XLEN-1:0] rs1_val;
    logic [gpu_isa_pkg::XLEN-1:0] rs2_val;
    logic                         read_fire;

    // The slot can take a new item when empty or being drained now
    assign read_ready = !opnd_valid || opnd_ready;
    assign read_fire  = read_valid && read_ready;

    // Register 0 reads as zero and is never stored
    always_comb begin
        rs1_val = '0;
        rs2_val = '0;
        if (read_req.inst.rs1 != '0) begin
            rs1_val = regs[read_req.inst.wid][read_req.inst.rs1];
        end
        if (read_req.inst.rs2 != '0) begin
            rs2_val = regs[read_req.inst.wid][read_req.inst.rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid && (wb.rd != '0)) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                if (wb.wid == WB'(w)) begin
                    regs[w][wb.rd] <= wb.data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_fire) begin
            opnd.req      <= read_req;
            opnd.rs1_data <= rs1_val;
            opnd.rs2_data <= rs2_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opnd_valid <= 1'b0;
        end else if (read_ready) begin
            opnd_valid <= read_valid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_pkg.sv ====
/*
 * Issue pipeline types
 * Packed structs exchanged between the issue-stage blocks and
 * with the decode, writeback and execute ports
 */
`default_nettype none

package issue_pkg;

    // One decoded instruction as it enters the instruction buffer
    typedef struct packed {
        logic [gpu_isa_pkg::WID_BITS-1:0] wid;
        logic [gpu_isa_pkg::XLEN-1:0]     pc;
        gpu_isa_pkg::opcode_e             op;
        logic [gpu_isa_pkg::REG_BITS-1:0] rd;
        logic [gpu_isa_pkg::REG_BITS-1:0] rs1;
        logic [gpu_isa_pkg::REG_BITS-1:0] rs2;
        logic                             use_imm;
        logic [gpu_isa_pkg::IMM_BITS-1:0] imm;
    } decode_t;

    // Result returning from an execute unit
    typedef struct packed {
        logic [gpu_isa_pkg::WID_BITS-1:0] wid;
        logic [gpu_isa_pkg::REG_BITS-1:0] rd;
        logic [gpu_isa_pkg::XLEN-1:0]     data;
    } writeback_t;

    // Instruction picked by the scheduler, with its writeback flag
    typedef struct packed {
        decode_t inst;
        logic    wb;
    } read_req_t;

    typedef struct packed {
        read_req_t                    req;
        logic [gpu_isa_pkg::XLEN-1:0] rs1_data;
        logic [gpu_isa_pkg::XLEN-1:0] rs2_data;
    } operands_t;

    typedef struct packed {
        logic [gpu_isa_pkg::WID_BITS-1:0] wid;
        logic [gpu_isa_pkg::XLEN-1:0]     pc;
        gpu_isa_pkg::opcode_e             op;
        logic                             wb;
        logic [gpu_isa_pkg::REG_BITS-1:0] rd;
        logic [gpu_isa_pkg::XLEN-1:0]     a;
        logic [gpu_isa_pkg::XLEN-1:0]     b;
    } alu_req_t;

    typedef struct packed {
        logic [gpu_isa_pkg::WID_BITS-1:0] wid;
        logic [gpu_isa_pkg::XLEN-1:0]     pc;
        logic                             is_store;
        logic                             wb;
        logic [gpu_isa_pkg::REG_BITS-1:0] rd;
        logic [gpu_isa_pkg::XLEN-1:0]     addr;
        logic [gpu_isa_pkg::XLEN-1:0]     wdata;
    } lsu_req_t;

endpackage

`default_nettype wire

// ==== verilog/issue_scheduler.sv ====
/*
 * Issue scheduler
 * Tracks pending destination registers per warp, picks a hazard-free
 * warp round-robin, pops its buffer head and counts stall cycles
 */
`default_nettype none

module issue_scheduler #(
    parameter int NUM_WARPS = 4,
    parameter int PERF_BITS = 16
) (
    input  wire                                clk,
    input  wire                                reset,

    input  wire  [NUM_WARPS-1:0]               head_valid,
    input  issue_pkg::decode_t [NUM_WARPS-1:0] head,
    output logic [NUM_WARPS-1:0]               pop,

    input  wire                                decode_valid,
    input  wire                                decode_ready,

    input  wire                                wb_valid,
    input  issue_pkg::writeback_t              wb,

    output logic                               read_valid,
    output issue_pkg::read_req_t               read_req,
    input  wire                                read_ready,

    output logic [PERF_BITS-1:0]               ibuf_stalls,
    output logic [PERF_BITS-1:0]               scb_stalls
);

    localparam int WB = gpu_isa_pkg::WID_BITS;

    logic [NUM_WARPS-1:0][gpu_isa_pkg::NUM_REGS-1:0] pending;

    logic [NUM_WARPS-1:0] eligible;
    logic [WB-1:0]        last_wid;
    logic [WB-1:0]        sel_wid;
    logic                 sel_found;
    logic                 sel_wb;
    issue_pkg::decode_t   sel_inst;

    // A head may go only when none of its registers is still in flight
    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            eligible[w] = head_valid[w] &&
                          !pending[w][head[w].rs1] &&
                          !pending[w][head[w].rs2] &&
                          !pending[w][head[w].rd];
        end
    end

    // Round-robin search starting one past the last issued warp
    always_comb begin
        int unsigned idx;
        sel_found = 1'b0;
        sel_wid   = '0;
        for (int i = 1; i <= NUM_WARPS; i++) begin
            idx = (int'(last_wid) + i) % NUM_WARPS;
            if (!sel_found && eligible[idx]) begin
                sel_found = 1'b1;
                sel_wid   = WB'(idx);
            end
        end
    end

    assign sel_inst = head[sel_wid];
    assign sel_wb   = (sel_inst.op != gpu_isa_pkg::OP_STORE) && (sel_inst.rd != '0);

    // The pick is offered only when the operands stage can take it,
    // so it never changes while waiting
    assign read_valid    = sel_found && read_ready;
    assign read_req.inst = sel_inst;
    assign read_req.wb   = sel_wb;

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            pop[w] = read_valid && (sel_wid == WB'(w));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending  <= '0;
            last_wid <= WB'(NUM_WARPS - 1);
        end else begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                if (wb_valid && (wb.wid == WB'(w))) begin
                    pending[w][wb.rd] <= 1'b0;
                end
            end
            // Setting after clearing lets a new claim win on the same register
            if (read_valid) begin
                last_wid <= sel_wid;
                if (sel_wb) begin
                    pending[sel_wid][sel_inst.rd] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ibuf_stalls <= '0;
            scb_stalls  <= '0;
        end else begin
            if (decode_valid && !decode_ready) begin
                ibuf_stalls <= ibuf_stalls + PERF_BITS'(1);
            end
            // Covers both hazards and downstream back-pressure
            if ((|head_valid) && !read_valid) begin
                scb_stalls <= scb_stalls + PERF_BITS'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_top.sv ====
/*
 * Issue stage top level
 * Instruction buffer, scheduler, operand read and dispatch in series
 */
`default_nettype none

module issue_top #(
    parameter int NUM_WARPS  = 4,
    parameter int IBUF_DEPTH = 4,
    parameter int PERF_BITS  = 16
) (
    input  wire                   clk,
    input  wire                   reset,

    input  wire                   decode_valid,
    input  issue_pkg::decode_t    decode,
    output logic                  decode_ready,

    input  wire                   wb_valid,
    input  issue_pkg::writeback_t wb,

    output logic                  alu_valid,
    output issue_pkg::alu_req_t   alu_req,
    input  wire                   alu_ready,

    output logic                  lsu_valid,
    output issue_pkg::lsu_req_t   lsu_req,
    input  wire                   lsu_ready,

    output logic [PERF_BITS-1:0]  ibuf_stalls,
    output logic [PERF_BITS-1:0]  scb_stalls
);

    logic [NUM_WARPS-1:0]               head_valid;
    issue_pkg::decode_t [NUM_WARPS-1:0] head;
    logic [NUM_WARPS-1:0]               pop;

    logic                 read_valid;
    issue_pkg::read_req_t read_req;
    logic                 read_ready;

    logic                 opnd_valid;
    issue_pkg::operands_t opnd;
    logic                 opnd_ready;

    issue_ibuffer #(
        .NUM_WARPS  (NUM_WARPS),
        .IBUF_DEPTH (IBUF_DEPTH)
    ) i_ibuffer (
        .clk          (clk),
        .reset        (reset),
        .decode_valid (decode_valid),
        .decode       (decode),
        .decode_ready (decode_ready),
        .head_valid   (head_valid),
        .head         (head),
        .pop          (pop)
    );

    issue_scheduler #(
        .NUM_WARPS (NUM_WARPS),
        .PERF_BITS (PERF_BITS)
    ) i_scheduler (
        .clk          (clk),
        .reset        (reset),
        .head_valid   (head_valid),
        .head         (head),
        .pop          (pop),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .read_valid   (read_valid),
        .read_req     (read_req),
        .read_ready   (read_ready),
        .ibuf_stalls  (ibuf_stalls),
        .scb_stalls   (scb_stalls)
    );

    issue_operands #(
        .NUM_WARPS (NUM_WARPS)
    ) i_operands (
        .clk        (clk),
        .reset      (reset),
        .read_valid (read_valid),
        .read_req   (read_req),
        .read_ready (read_ready),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .opnd_valid (opnd_valid),
        .opnd       (opnd),
        .opnd_ready (opnd_ready)
    );

    issue_dispatch i_dispatch (
        .clk        (clk),
        .reset      (reset),
        .opnd_valid (opnd_valid),
        .opnd       (opnd),
        .opnd_ready (opnd_ready),
        .alu_valid  (alu_valid),
        .alu_req    (alu_req),
        .alu_ready  (alu_ready),
        .lsu_valid  (lsu_valid),
        .lsu_req    (lsu_req),
        .lsu_ready  (lsu_ready)
    );

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/gpu_isa_pkg.sv
verilog/issue_pkg.sv
verilog/issue_ibuffer.sv
verilog/issue_scheduler.sv
verilog/issue_operands.sv
verilog/issue_dispatch.sv
verilog/issue_top.sv
testbench/issue_tb.sv
